/* design/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus widths, in bits.
`define MEM_ADDR_BITS 16
`define MEM_DATA_BITS 16

// address bits [15:13] pick the region.
`define MEM_SEL_LSB 13

// ram layout, interleaved on the low address bits.
`define MEM_NUM_BANKS 4
`define MEM_BANK_WORDS 64

// outstanding requests tracked by the merger.
`define MEM_ORDER_DEPTH 8

`endif

/* design/mem_pkg.sv */
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [`MEM_DATA_BITS-1:0] mem_data_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // result of the address decode.
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_PORT,
        REGION_NONE
    } region_e;

    // banks must stay at codes 0..3, the bank index maps onto them.
    typedef enum logic [2:0] {
        TGT_BANK0 = 3'd0,
        TGT_BANK1 = 3'd1,
        TGT_BANK2 = 3'd2,
        TGT_BANK3 = 3'd3,
        TGT_PORT  = 3'd4,
        TGT_ERROR = 3'd5
    } target_e;

endpackage

/* design/mem_if.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

// request channel from the router to one target.
interface mem_req_if;
    import mem_pkg::*;

    localparam int WORD_BITS = $clog2(`MEM_BANK_WORDS);

    logic valid;
    logic ready;
    mem_op_e op;
    logic [WORD_BITS-1:0] word; // in-bank index.
    mem_data_t wdata;

    modport source (
        output valid, op, word, wdata,
        input ready
    );

    modport sink (
        input valid, op, word, wdata,
        output ready
    );
endinterface

// response channel from one target to the merger.
interface mem_rsp_if;
    import mem_pkg::*;

    logic valid;
    logic ready;
    mem_data_t rdata;

    modport source (
        output valid, rdata,
        input ready
    );

    modport sink (
        input valid, rdata,
        output ready
    );
endinterface

/* design/bus_router.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module bus_router (
    input logic req_valid,
    output logic req_ready,
    input mem_pkg::mem_op_e req_op,
    input mem_pkg::mem_addr_t req_addr,
    input mem_pkg::mem_data_t req_wdata,
    mem_req_if.source bank [`MEM_NUM_BANKS],
    mem_req_if.source port,
    output logic ord_push,
    output mem_pkg::target_e ord_target,
    input logic ord_full
);
    import mem_pkg::*;

    localparam int BANK_BITS = $clog2(`MEM_NUM_BANKS);
    localparam int WORD_BITS = $clog2(`MEM_BANK_WORDS);
    localparam int RAM_WORDS = `MEM_NUM_BANKS * `MEM_BANK_WORDS;
    localparam int SEL_BITS = `MEM_ADDR_BITS - `MEM_SEL_LSB;

    logic [SEL_BITS-1:0] sel;
    logic [BANK_BITS-1:0] bank_idx;
    logic [WORD_BITS-1:0] word_idx;
    logic [`MEM_NUM_BANKS-1:0] bank_ready;
    region_e region;
    target_e tgt;
    logic tgt_ready;
    logic accept;

    assign sel = req_addr[`MEM_ADDR_BITS-1:`MEM_SEL_LSB];
    assign bank_idx = req_addr[BANK_BITS-1:0];
    assign word_idx = req_addr[BANK_BITS +: WORD_BITS];

    always_comb begin
        if (sel == '0 && req_addr[`MEM_SEL_LSB-1:0] < RAM_WORDS)
            region = REGION_RAM;
        else if (sel == '1)
            region = REGION_PORT;
        else
            region = REGION_NONE; // also ram region above the last word.
    end

    always_comb begin
        case (region)
            REGION_RAM: begin
                tgt = target_e'({1'b0, bank_idx});
                tgt_ready = bank_ready[bank_idx];
            end
            REGION_PORT: begin
                tgt = TGT_PORT;
                tgt_ready = port.ready;
            end
            default: begin
                tgt = TGT_ERROR;
                tgt_ready = 1'b1; // answered by the merger alone.
            end
        endcase
    end

    assign req_ready = tgt_ready && !ord_full;
    assign accept = req_valid && req_ready;

    assign ord_push = accept;
    assign ord_target = tgt;

    for (genvar g = 0; g < `MEM_NUM_BANKS; g++) begin : g_bank
        assign bank_ready[g] = bank[g].ready;
        assign bank[g].valid = accept && region == REGION_RAM && bank_idx == BANK_BITS'(g);
        assign bank[g].op = req_op;
        assign bank[g].word = word_idx;
        assign bank[g].wdata = req_wdata;
    end

    assign port.valid = accept && region == REGION_PORT;
    assign port.op = req_op;
    assign port.word = word_idx;
    assign port.wdata = req_wdata;

endmodule

/* design/ram_bank.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module ram_bank (
    input logic clk,
    input logic rst,
    mem_req_if.sink req,
    mem_rsp_if.source rsp
);
    import mem_pkg::*;

    mem_data_t mem [`MEM_BANK_WORDS];
    mem_data_t rdata_q;
    logic valid_q;
    logic take;

    // free slot, or the held word leaves this cycle.
    assign req.ready = !valid_q || rsp.ready;
    assign take = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (rsp.ready) begin
            valid_q <= 1'b0;
        end
    end

    // old word goes out, new word goes in.
    always_ff @(posedge clk) begin
        if (take) begin
            rdata_q <= mem[req.word];
            if (req.op == MEM_WRITE)
                mem[req.word] <= req.wdata;
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.rdata = rdata_q;

endmodule

/* design/io_port.sv */
`timescale 1ns/1ps

module io_port (
    input logic clk,
    input logic rst,
    mem_req_if.sink req,
    mem_rsp_if.source rsp,
    output logic led
);
    import mem_pkg::*;

    logic led_q;
    logic valid_q;
    mem_data_t rdata_q;
    logic take;

    assign req.ready = !valid_q || rsp.ready;
    assign take = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            led_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (take && req.op == MEM_WRITE)
                led_q <= req.wdata[0];
            if (take)
                valid_q <= 1'b1;
            else if (rsp.ready)
                valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            rdata_q <= mem_data_t'(led_q); // state before this access.
    end

    assign rsp.valid = valid_q;
    assign rsp.rdata = rdata_q;
    assign led = led_q;

endmodule

/* design/resp_merger.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module resp_merger (
    input logic clk,
    input logic rst,
    input logic ord_push,
    input mem_pkg::target_e ord_target,
    output logic ord_full,
    mem_rsp_if.sink bank [`MEM_NUM_BANKS],
    mem_rsp_if.sink port,
    output logic rsp_valid,
    input logic rsp_ready,
    output mem_pkg::mem_data_t rsp_rdata,
    output logic rsp_err
);
    import mem_pkg::*;

    localparam int PTR_BITS = $clog2(`MEM_ORDER_DEPTH);
    localparam int CNT_BITS = $clog2(`MEM_ORDER_DEPTH + 1);
    localparam int BANK_BITS = $clog2(`MEM_NUM_BANKS);

    target_e order_q [`MEM_ORDER_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    target_e head;
    logic [BANK_BITS-1:0] head_bank;
    logic head_is_bank;
    logic empty;
    logic pop;

    logic [`MEM_NUM_BANKS-1:0] bank_valid;
    mem_data_t bank_rdata [`MEM_NUM_BANKS];

    assign head = order_q[rd_ptr];
    assign head_bank = head[BANK_BITS-1:0];
    assign head_is_bank = head inside {TGT_BANK0, TGT_BANK1, TGT_BANK2, TGT_BANK3};
    assign empty = count == '0;
    assign ord_full = count == CNT_BITS'(`MEM_ORDER_DEPTH);

    always_ff @(posedge clk) begin
        if (ord_push)
            order_q[wr_ptr] <= ord_target;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (ord_push)
                wr_ptr <= (wr_ptr == PTR_BITS'(`MEM_ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_BITS'(`MEM_ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (ord_push && !pop)
                count <= count + 1'b1;
            else if (pop && !ord_push)
                count <= count - 1'b1;
        end
    end

    for (genvar g = 0; g < `MEM_NUM_BANKS; g++) begin : g_bank
        assign bank_valid[g] = bank[g].valid;
        assign bank_rdata[g] = bank[g].rdata;
        assign bank[g].ready = pop && head_is_bank && head_bank == BANK_BITS'(g);
    end

    // the head entry alone decides which response goes out.
    always_comb begin
        rsp_valid = 1'b0;
        rsp_rdata = '0;
        rsp_err = 1'b0;
        if (!empty) begin
            case (head)
                TGT_PORT: begin
                    rsp_valid = port.valid;
                    rsp_rdata = port.rdata;
                end
                TGT_ERROR: begin
                    rsp_valid = 1'b1; // nothing to wait for.
                    rsp_err = 1'b1;
                end
                default: begin
                    rsp_valid = bank_valid[head_bank];
                    rsp_rdata = bank_rdata[head_bank];
                end
            endcase
        end
    end

    assign pop = rsp_valid && rsp_ready;
    assign port.ready = pop && head == TGT_PORT;

endmodule

/* design/mem_system.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_system (
    input logic clk,
    input logic rst,
    input logic req_valid,
    output logic req_ready,
    input mem_pkg::mem_op_e req_op,
    input mem_pkg::mem_addr_t req_addr,
    input mem_pkg::mem_data_t req_wdata,
    output logic rsp_valid,
    input logic rsp_ready,
    output mem_pkg::mem_data_t rsp_rdata,
    output logic rsp_err,
    output logic led
);
    import mem_pkg::*;

    mem_req_if bank_req [`MEM_NUM_BANKS] ();
    mem_rsp_if bank_rsp [`MEM_NUM_BANKS] ();
    mem_req_if port_req ();
    mem_rsp_if port_rsp ();

    logic ord_push;
    logic ord_full;
    target_e ord_target;

    bus_router u_router (
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_op(req_op),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .bank(bank_req),
        .port(port_req),
        .ord_push(ord_push),
        .ord_target(ord_target),
        .ord_full(ord_full)
    );

    for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
        ram_bank u_bank (
            .clk(clk),
            .rst(rst),
            .req(bank_req[b]),
            .rsp(bank_rsp[b])
        );
    end

    io_port u_port (
        .clk(clk),
        .rst(rst),
        .req(port_req),
        .rsp(port_rsp),
        .led(led)
    );

    // responses leave in acceptance order.
    resp_merger u_merger (
        .clk(clk),
        .rst(rst),
        .ord_push(ord_push),
        .ord_target(ord_target),
        .ord_full(ord_full),
        .bank(bank_rsp),
        .port(port_rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_rdata(rsp_rdata),
        .rsp_err(rsp_err)
    );

endmodule

/* verification/mem_system_props.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_system_props (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_ready,
    input mem_pkg::mem_op_e req_op,
    input mem_pkg::mem_addr_t req_addr,
    input mem_pkg::mem_data_t req_wdata,
    input logic rsp_valid,
    input logic rsp_ready,
    input mem_pkg::mem_data_t rsp_rdata,
    input logic rsp_err,
    input logic [$clog2(`MEM_ORDER_DEPTH + 1)-1:0] ord_count
);

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_op)
            && $stable(req_addr) && $stable(req_wdata))
        else $error("request payload changed while stalled");

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err))
        else $error("response payload changed while stalled");

    a_rsp_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
        else $error("rsp_valid high right after reset");

    // order queue never overfills.
    a_count: assert property (@(posedge clk) disable iff (rst)
        ord_count <= `MEM_ORDER_DEPTH)
        else $error("order queue count above depth");

endmodule

bind mem_system mem_system_props u_props (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_op(req_op),
    .req_addr(req_addr),
    .req_wdata(req_wdata),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_rdata(rsp_rdata),
    .rsp_err(rsp_err),
    .ord_count(u_merger.count)
);

/* verification/mem_system_tb.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_system_tb;
    import mem_pkg::*;

    localparam int RAM_WORDS = `MEM_NUM_BANKS * `MEM_BANK_WORDS;
    localparam int SEL_SPAN = 1 << `MEM_SEL_LSB; // words per region.
    localparam int N_MIX = 200;
    localparam int N_PORT = 16;
    localparam int N_ERR = 24;
    localparam int N_CHK = 17;
    localparam int N_BURST = 300;
    localparam int N_TOTAL = 2 * RAM_WORDS + N_MIX + N_PORT + N_ERR + N_CHK + N_BURST;
    localparam int LIMIT = N_TOTAL * 20 + 200;
    localparam logic [31:0] SEED = 32'd80;

    typedef struct {
        mem_data_t data;
        bit err;
        bit known; // false while the word has never been written.
        bit is_port;
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    logic req_ready;
    mem_op_e req_op;
    mem_addr_t req_addr;
    mem_data_t req_wdata;
    logic rsp_valid;
    logic rsp_ready;
    mem_data_t rsp_rdata;
    logic rsp_err;
    logic led;

    mem_data_t ram_m [RAM_WORDS];
    bit written_m [RAM_WORDS];
    bit led_m;
    exp_t exp_q [$];
    logic [31:0] rnd;
    logic [31:0] stall_rnd;
    bit use_gaps;
    bit stall_on;
    int order [RAM_WORDS];
    int n_acc;
    int n_rsp;
    int cycles;
    int data_errs;
    int err_errs;
    int led_errs;
    int other_errs;

    mem_system UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand32(output logic [31:0] r);
        rnd = xorshift(rnd);
        r = rnd;
    endtask

    function automatic region_e region_of(input mem_addr_t a);
        if (a[15:13] == 3'd0 && a < RAM_WORDS)
            return REGION_RAM;
        if (a[15:13] == 3'd7)
            return REGION_PORT;
        return REGION_NONE;
    endfunction

    // regions 1..6, or ram region past the last word.
    function automatic mem_addr_t bad_addr(input logic [31:0] r);
        if (r[1])
            return {3'(r[10:2] % 6 + 1), r[23:11]};
        return mem_addr_t'(RAM_WORDS + r[31:12] % (SEL_SPAN - RAM_WORDS));
    endfunction

    task automatic check_data(input mem_data_t exp, input mem_data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("ERR %0t: rdata expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_err(input bit exp, input bit act);
        if (act !== exp) begin
            err_errs++;
            $display("ERR %0t: rsp_err expected %b, got %b", $time, exp, act);
        end
    endtask

    task automatic check_led(input bit exp, input bit act);
        if (act !== exp) begin
            led_errs++;
            $display("ERR %0t: led expected %b, got %b", $time, exp, act);
        end
    endtask

    // model update at the request transfer.
    task automatic expect_response(input mem_op_e op, input mem_addr_t a, input mem_data_t d);
        exp_t e;
        e = '{data: '0, err: 1'b0, known: 1'b1, is_port: 1'b0};
        case (region_of(a))
            REGION_RAM: begin
                e.data = ram_m[a];
                e.known = written_m[a];
                if (op == MEM_WRITE) begin
                    ram_m[a] = d;
                    written_m[a] = 1'b1;
                end
            end
            REGION_PORT: begin
                e.data = mem_data_t'(led_m);
                e.is_port = 1'b1;
                if (op == MEM_WRITE)
                    led_m = d[0];
            end
            default: e.err = 1'b1;
        endcase
        exp_q.push_back(e);
    endtask

    task automatic take_response();
        exp_t e;
        n_rsp++;
        if (exp_q.size() == 0) begin
            other_errs++;
            $display("response at %0t with no request outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            check_err(e.err, rsp_err);
            if (e.known)
                check_data(e.data, rsp_rdata);
            if (e.is_port)
                check_led(led_m, led); // model holds every earlier transfer.
        end
    endtask

    // responses first, so the model still matches the dut state.
    always @(posedge clk) begin
        if (!rst) begin
            if (rsp_valid && rsp_ready)
                take_response();
            if (req_valid && req_ready) begin
                n_acc++;
                expect_response(req_op, req_addr, req_wdata);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("run timed out with %0d responses outstanding", exp_q.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rsp_ready = 1'b1;
        stall_rnd = SEED ^ 32'h2545f491;
        forever begin
            @(negedge clk);
            stall_rnd = xorshift(stall_rnd);
            rsp_ready = !stall_on || stall_rnd[4];
        end
    end

    task automatic send(input mem_op_e op, input mem_addr_t a, input mem_data_t d);
        logic [31:0] r;
        int want;
        if (use_gaps) begin
            rand32(r);
            repeat (r[1:0]) @(negedge clk);
        end
        want = n_acc + 1;
        req_valid = 1'b1;
        req_op = op;
        req_addr = a;
        req_wdata = d;
        @(negedge clk);
        while (n_acc < want)
            @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_random(input bit any_target);
        logic [31:0] r;
        logic [31:0] d;
        mem_addr_t a;
        rand32(r);
        rand32(d);
        if (!any_target || r[7:4] < 4'd12)
            a = mem_addr_t'(r[31:16] % RAM_WORDS);
        else if (r[7:4] < 4'd14)
            a = {3'b111, r[28:16]};
        else
            a = bad_addr(r);
        send(mem_op_e'(r[0]), a, d[15:0]);
    endtask

    initial begin
        logic [31:0] r;
        int j;
        int tmp;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = MEM_READ;
        req_addr = '0;
        req_wdata = '0;
        rnd = SEED;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // fill in shuffled order, then read back.
        use_gaps = 1'b1;
        for (int i = 0; i < RAM_WORDS; i++)
            order[i] = i;
        for (int i = RAM_WORDS - 1; i > 0; i--) begin
            rand32(r);
            j = r % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            rand32(r);
            send(MEM_WRITE, mem_addr_t'(order[i]), r[15:0]);
        end
        for (int i = 0; i < RAM_WORDS; i++)
            send(MEM_READ, mem_addr_t'(i), '0);

        use_gaps = 1'b0; // back-to-back ram mix.
        for (int i = 0; i < N_MIX; i++)
            send_random(1'b0);

        use_gaps = 1'b1;
        for (int i = 0; i < N_PORT; i++) begin
            rand32(r);
            send(mem_op_e'(r[0]), {3'b111, r[28:16]}, r[31:16]);
        end

        for (int i = 0; i < N_ERR; i++) begin
            rand32(r);
            send(mem_op_e'(r[0]), bad_addr(r), r[31:16]);
        end
        for (int i = 0; i < N_CHK - 1; i++) begin
            rand32(r);
            send(MEM_READ, mem_addr_t'(r[15:0] % RAM_WORDS), '0);
        end
        send(MEM_READ, 16'he000, '0);

        use_gaps = 1'b0;
        stall_on <= 1'b1;
        for (int i = 0; i < N_BURST; i++)
            send_random(1'b1);

        while (exp_q.size() != 0)
            @(negedge clk);
        stall_on <= 1'b0;
        repeat (2) @(negedge clk);
        if (n_rsp != n_acc) begin
            other_errs++;
            $display("%0d responses for %0d accepted requests", n_rsp, n_acc);
        end
        $display("errors: data %0d, err flag %0d, led %0d, other %0d",
            data_errs, err_errs, led_errs, other_errs);
        if (data_errs + err_errs + led_errs + other_errs == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+design
design/mem_pkg.sv
design/mem_if.sv
design/bus_router.sv
design/ram_bank.sv
design/io_port.sv
design/resp_merger.sv
design/mem_system.sv
verification/mem_system_props.sv
verification/mem_system_tb.sv

/* Bender.yml */
package:
  name: mem_system

export_include_dirs:
  - design

sources:
  - design/mem_pkg.sv
  - design/mem_if.sv
  - design/bus_router.sv
  - design/ram_bank.sv
  - design/io_port.sv
  - design/resp_merger.sv
  - design/mem_system.sv
  - target: test
    files:
      - verification/mem_system_props.sv
      - verification/mem_system_tb.sv
